/* tb.f */
+incdir+verilog
verilog/pkt_pkg.sv
verilog/mem_rd_if.sv
verilog/req_fifo.sv
verilog/operand_mem.sv
verilog/packetizer_cu.sv
verilog/pe_packetizer_top.sv
tb/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    // routing header per PE node
    // nodes 14 and 15 take the node 0 route
    localparam logic [7:0] hdr_ref [16] = '{
        8'hE3, 8'hF3, 8'hFB, 8'hC3, 8'hD3, 8'hDB, 8'hDF, 8'h83,
        8'h93, 8'h9B, 8'h9F, 8'h13, 8'h1B, 8'h1F, 8'hE3, 8'hE3
    };
    localparam int wait_limit = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic [17:0] req_data;
    logic        fil_size_we;
    logic [1:0]  fil_size;
    logic        ld_en;
    logic        ld_sel_fil;
    logic [12:0] ld_addr;
    logic [39:0] ld_data;
    logic        pkt_valid;
    logic        pkt_ready = 1'b0;
    logic [52:0] pkt_data;

    // shadow copies of both memories
    logic [39:0] fil_shadow [8];
    logic [24:0] if_shadow [8192];
    // expected packets in request order
    logic [52:0] exp_q [$];
    logic [1:0]  fs_model;
    logic [31:0] rng = 32'hb040;
    // separate stream for pkt_ready
    logic [31:0] rdy_rng = ~32'hb040;
    // pkt_ready mode 0 keeps it high, 1 randomizes it, 2 holds it low
    int          rdy_mode = 0;
    int          errors = 0;
    int          checks = 0;
    int          sent = 0;
    int          rcvd = 0;
    int          tests = 0;
    int          err_mark = 0;
    // last cycle's stalled packet
    logic        stall_seen = 1'b0;
    logic [52:0] stall_data;

    pe_packetizer_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_data    (req_data),
        .fil_size_we (fil_size_we),
        .fil_size    (fil_size),
        .ld_en       (ld_en),
        .ld_sel_fil  (ld_sel_fil),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data),
        .pkt_valid   (pkt_valid),
        .pkt_ready   (pkt_ready),
        .pkt_data    (pkt_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // packet layout for both job types with unused bits at zero
    function automatic logic [52:0] expect_pkt(input logic [17:0] r, input logic [1:0] fs);
        logic [52:0] p;
        p = '0;
        p[7:0] = hdr_ref[r[3:0]];
        if (r[4]) begin
            p[9] = 1'b1;
            p[12:10] = r[7:5];
            p[52:13] = fil_shadow[r[7:5]];
        end else begin
            p[8] = r[5];
            p[14:13] = fs;
            p[26:15] = r[17:6];
            p[52:28] = if_shadow[r[17:5]];
        end
        return p;
    endfunction

    task automatic load_word(input logic sel, input logic [12:0] addr, input logic [39:0] data);
        ld_en = 1'b1;
        ld_sel_fil = sel;
        ld_addr = addr;
        ld_data = data;
        @(posedge clk);
        #1;
        ld_en = 1'b0;
    endtask

    task automatic set_filter_size(input logic [1:0] v);
        fil_size_we = 1'b1;
        fil_size = v;
        @(posedge clk);
        #1;
        fil_size_we = 1'b0;
        fs_model = v;
    endtask

    // the expected packet is queued at the accepting edge
    task automatic send_req(input logic [17:0] r);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        req_valid = 1'b1;
        req_data = r;
        while (!done && n < wait_limit) begin
            @(posedge clk);
            n++;
            done = req_ready;
        end
        if (done) begin
            exp_q.push_back(expect_pkt(r, fs_model));
            sent++;
        end else begin
            errors++;
            $display("request %h was not accepted within %0d cycles", r, wait_limit);
        end
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < wait_limit * 4) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d packets never came out", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // mode is read at the edge and ready is driven just after it
    always @(posedge clk) begin
        int mode_now;
        mode_now = rdy_mode;
        #1;
        rdy_rng = xorshift32(rdy_rng);
        case (mode_now)
            0:       pkt_ready = 1'b1;
            1:       pkt_ready = rdy_rng[7];
            default: pkt_ready = 1'b0;
        endcase
    end

    // scoreboard compares every accepted packet
    always @(posedge clk) begin
        logic [52:0] exp_pkt;
        if (rst_n && pkt_valid && pkt_ready) begin
            checks++;
            rcvd++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("packet %h came out with no request pending", pkt_data);
            end
            if (exp_q.size() != 0) begin
                exp_pkt = exp_q.pop_front();
                assert (pkt_data == exp_pkt) else begin
                    errors++;
                    $display("Fail %0t pkt_data: got %h expected %h", $time, pkt_data, exp_pkt);
                end
                // ifmap packets keep bit 9, the row slot and bit 27 clear
                if (!exp_pkt[9]) begin
                    assert (pkt_data[12:9] == 4'b0000 && !pkt_data[27]) else begin
                        errors++;
                        $display("Fail %0t pkt_data[12:9] and [27]: got %b %b expected 0000 0",
                                 $time, pkt_data[12:9], pkt_data[27]);
                    end
                end
            end
        end
    end

    // a stalled packet must not change
    always @(posedge clk) begin
        if (rst_n && stall_seen) begin
            checks++;
            assert (pkt_data == stall_data) else begin
                errors++;
                $display("Fail %0t pkt_data: got %h expected %h", $time, pkt_data, stall_data);
            end
        end
        stall_seen <= rst_n && pkt_valid && !pkt_ready;
        stall_data <= pkt_data;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (pkt_valid && !pkt_ready) |=> pkt_valid) else begin
        errors++;
        $display("pkt_valid dropped at %0t before the packet was taken", $time);
    end

    initial begin
        logic [7:0] hi;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_data = '0;
        fil_size_we = 1'b0;
        fil_size = 2'b00;
        ld_en = 1'b0;
        ld_sel_fil = 1'b0;
        ld_addr = '0;
        ld_data = '0;
        fs_model = 2'b00;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        checks++;
        assert (!pkt_valid) else begin
            errors++;
            $display("Fail %0t pkt_valid: got %b expected 0", $time, pkt_valid);
        end
        checks++;
        assert (req_ready) else begin
            errors++;
            $display("Fail %0t req_ready: got %b expected 1", $time, req_ready);
        end
        report_test("reset values");

        // fill both memories and their shadows
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            hi = rng[7:0];
            rng = xorshift32(rng);
            fil_shadow[i] = {hi, rng};
            load_word(1'b1, 13'(i), {hi, rng});
        end
        for (int i = 0; i < 8192; i++) begin
            rng = xorshift32(rng);
            if_shadow[i] = rng[24:0];
            load_word(1'b0, 13'(i), {15'd0, rng[24:0]});
        end

        // every node and every row
        // upper request bits are noise
        for (int n = 0; n < 16; n++) begin
            for (int r = 0; r < 8; r++) begin
                rng = xorshift32(rng);
                send_req({rng[17:8], 3'(r), 1'b1, 4'(n)});
            end
        end
        wait_drain();
        report_test("filter jobs");

        // size changes only while nothing is in flight
        for (int j = 0; j < 40; j++) begin
            if (j % 5 == 0) begin
                wait_drain();
                rng = xorshift32(rng);
                set_filter_size(rng[9:8]);
            end
            rng = xorshift32(rng);
            send_req({rng[17:5], 1'b0, rng[3:0]});
        end
        wait_drain();
        report_test("ifmap jobs");

        // one packet stalled in send plus four queued fills the FIFO
        for (int k = 0; k < 8; k++) begin
            rdy_mode = 2;
            for (int m = 0; m < 5; m++) begin
                rng = xorshift32(rng);
                send_req(rng[17:0]);
            end
            @(posedge clk);
            checks++;
            assert (!req_ready) else begin
                errors++;
                $display("Fail %0t req_ready: got %b expected 0", $time, req_ready);
            end
            rng = xorshift32(rng);
            repeat (2 + rng[3:0]) @(posedge clk);
            #1;
            rdy_mode = 1;
            wait_drain();
        end
        report_test("back-pressure");

        // random mix with gaps and random ready
        rdy_mode = 1;
        for (int t = 0; t < 200; t++) begin
            rng = xorshift32(rng);
            if (rng[31:29] == 3'b000) begin
                @(posedge clk);
                #1;
            end
            send_req(rng[17:0]);
        end
        wait_drain();
        rdy_mode = 0;
        checks++;
        assert (sent == rcvd) else begin
            errors++;
            $display("%0d requests accepted but %0d packets received", sent, rcvd);
        end
        // nothing may follow the last expected packet
        checks++;
        assert (!pkt_valid) else begin
            errors++;
            $display("Fail %0t pkt_valid: got %b expected 0", $time, pkt_valid);
        end
        report_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verilog/pe_packetizer_top.sv */
`timescale 1ns/10ps

`include "pkt_defines.svh"

module pe_packetizer_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // scheduler requests
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic [`PKT_REQ_W-1:0]      req_data,
    // filter size for ifmap packets
    input  logic                       fil_size_we,
    input  logic [1:0]                 fil_size,
    // memory load port
    input  logic                       ld_en,
    input  logic                       ld_sel_fil,
    input  logic [`PKT_IF_ADDR_W-1:0]  ld_addr,
    input  logic [`PKT_FIL_DATA_W-1:0] ld_data,
    // packets toward the network
    output logic                       pkt_valid,
    input  logic                       pkt_ready,
    output logic [`PKT_OUT_W-1:0]      pkt_data
);

    import pkt_pkg::*;

    // FIFO head toward the control unit
    logic head_valid;
    logic head_ready;
    req_t head_data;

    // per-memory load enables
    logic fil_ld_en;
    logic if_ld_en;

    // ld_sel_fil steers the load to one memory
    assign fil_ld_en = ld_en && ld_sel_fil;
    assign if_ld_en  = ld_en && !ld_sel_fil;

    mem_rd_if #(.addr_t(fil_addr_t), .data_t(fil_data_t)) fil_rd ();
    mem_rd_if #(.addr_t(if_addr_t),  .data_t(if_data_t))  if_rd ();

    req_fifo u_req_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req_data),
        .out_valid (head_valid),
        .out_ready (head_ready),
        .out_data  (head_data)
    );

    // 8 filter rows of 40 bits
    operand_mem #(
        .addr_t (fil_addr_t),
        .data_t (fil_data_t),
        .depth  (2 ** `PKT_FIL_ADDR_W)
    ) u_fil_mem (
        .clk     (clk),
        .ld_en   (fil_ld_en),
        .ld_addr (ld_addr[`PKT_FIL_ADDR_W-1:0]),
        .ld_data (ld_data),
        .rd      (fil_rd)
    );

    // 8192 ifmap words of 25 bits
    operand_mem #(
        .addr_t (if_addr_t),
        .data_t (if_data_t),
        .depth  (2 ** `PKT_IF_ADDR_W)
    ) u_if_mem (
        .clk     (clk),
        .ld_en   (if_ld_en),
        .ld_addr (ld_addr),
        .ld_data (ld_data[`PKT_IF_DATA_W-1:0]),
        .rd      (if_rd)
    );

    packetizer_cu u_packetizer_cu (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_ready  (head_ready),
        .head_data   (head_data),
        .fil_size_we (fil_size_we),
        .fil_size    (fil_size),
        .fil_rd      (fil_rd),
        .if_rd       (if_rd),
        .pkt_valid   (pkt_valid),
        .pkt_ready   (pkt_ready),
        .pkt_data    (pkt_data)
    );

endmodule

/* verilog/packetizer_cu.sv */
`timescale 1ns/10ps

`include "pkt_defines.svh"

module packetizer_cu (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          head_valid,
    output logic          head_ready,
    input  pkt_pkg::req_t head_data,
    input  logic          fil_size_we,
    input  logic [1:0]    fil_size,
    mem_rd_if.requester   fil_rd,
    mem_rd_if.requester   if_rd,
    output logic          pkt_valid,
    input  logic          pkt_ready,
    output pkt_pkg::pkt_t pkt_data
);

    import pkt_pkg::*;

    typedef enum logic [1:0] {
        idle_s,
        wait_s,
        send_s
    } state_t;

    state_t state;
    state_t state_nxt;

    // filter size copied into ifmap packets
    logic [1:0] fil_size_q;

    // packet under construction, also the output register
    pkt_t pkt_q;

    // header part of the packet, built from the head request
    pkt_t pkt_init;

    logic pop;
    logic is_fil;
    logic rd_done;

    // job type of the request at the FIFO head
    assign is_fil = head_data[req_job_bit];

    // accept a new request only when no packet is pending
    assign head_ready = (state == idle_s);
    assign pop = head_valid && head_ready;

    // the read goes out in the same cycle as the pop
    assign fil_rd.rd_en   = pop && is_fil;
    assign fil_rd.rd_addr = head_data[req_row_msb:req_row_lsb];
    assign if_rd.rd_en    = pop && !is_fil;
    assign if_rd.rd_addr  = head_data[req_loc_msb:req_if_addr_lsb];

    // the stored job flag picks which memory answers
    assign rd_done = pkt_q[pkt_fil_bit] ? fil_rd.rd_valid : if_rd.rd_valid;

    assign pkt_valid = (state == send_s);
    assign pkt_data  = pkt_q;

    // header and routing fields, operand slot left at zero
    always_comb begin
        pkt_init = '0;
        pkt_init[pkt_hdr_msb:0] = hdr_table[head_data[req_node_msb:req_node_lsb]];
        if (is_fil) begin
            pkt_init[pkt_fil_bit] = 1'b1;
            pkt_init[pkt_row_msb:pkt_row_lsb] = head_data[req_row_msb:req_row_lsb];
        end else begin
            pkt_init[pkt_ts_bit] = head_data[req_ts_bit];
            // size as it stood before this edge
            pkt_init[pkt_fsz_msb:pkt_fsz_lsb] = fil_size_q;
            pkt_init[pkt_loc_msb:pkt_loc_lsb] = head_data[req_loc_msb:req_loc_lsb];
        end
    end

    // filter-size register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fil_size_q <= 2'b00;
        end else if (fil_size_we) begin
            fil_size_q <= fil_size;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            idle_s: begin
                if (pop) begin
                    state_nxt = wait_s;
                end
            end
            wait_s: begin
                // memory answers one cycle after the read
                if (rd_done) begin
                    state_nxt = send_s;
                end
            end
            send_s: begin
                // hold until the network takes the packet
                if (pkt_ready) begin
                    state_nxt = idle_s;
                end
            end
            default: begin
                state_nxt = idle_s;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle_s;
        end else begin
            state <= state_nxt;
        end
    end

    // packet assembly
    always_ff @(posedge clk) begin
        if (pop) begin
            pkt_q <= pkt_init;
        end else if ((state == wait_s) && rd_done) begin
            // operand lands in the upper slot for its job type
            if (pkt_q[pkt_fil_bit]) begin
                pkt_q[`PKT_OUT_W-1:pkt_fil_data_lsb] <= fil_rd.rd_data;
            end else begin
                pkt_q[`PKT_OUT_W-1:pkt_if_data_lsb] <= if_rd.rd_data;
            end
        end
    end

endmodule

/* verilog/operand_mem.sv */
`timescale 1ns/10ps

// operand storage for filter rows or ifmap words
module operand_mem #(
    parameter type addr_t = logic,
    parameter type data_t = logic,
    parameter int  depth  = 8
) (
    input  logic         clk,
    input  logic         ld_en,
    input  addr_t        ld_addr,
    input  data_t        ld_data,
    mem_rd_if.responder  rd
);

    // word array
    data_t mem [depth];

    // load port, filled before any request reads it
    always_ff @(posedge clk) begin
        if (ld_en) begin
            mem[ld_addr] <= ld_data;
        end
    end

    // registered read
    // data only updates on a request, the last word is held otherwise
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

    // response flag one cycle behind the request
    always_ff @(posedge clk) begin
        rd.rd_valid <= rd.rd_en;
    end

endmodule

/* verilog/req_fifo.sv */
`timescale 1ns/10ps

`include "pkt_defines.svh"

module req_fifo (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    output logic          in_ready,
    input  pkt_pkg::req_t in_data,
    output logic          out_valid,
    input  logic          out_ready,
    output pkt_pkg::req_t out_data
);

    import pkt_pkg::*;

    localparam int depth = `PKT_FIFO_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    // entry storage, no reset on payload
    req_t buf_mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic full;
    logic push;
    logic pop;

    // circular increment, works for any depth
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == cnt_w'(depth));

    // a full buffer still takes a word while the head drains
    assign in_ready  = !full || out_ready;
    assign out_valid = (count != '0);
    assign out_data  = buf_mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // write side
    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= in_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/mem_rd_if.sv */
`timescale 1ns/10ps

// one-cycle request/response read port
// rd_valid follows rd_en by exactly one cycle
interface mem_rd_if #(
    parameter type addr_t = logic,
    parameter type data_t = logic
) ();

    // request side
    logic  rd_en;
    addr_t rd_addr;

    // response side
    data_t rd_data;
    logic  rd_valid;

    // control unit issues reads
    modport requester (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    // memory answers them
    modport responder (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

/* verilog/pkt_pkg.sv */
`include "pkt_defines.svh"

package pkt_pkg;

    // request and packet vectors
    typedef logic [`PKT_REQ_W-1:0] req_t;
    typedef logic [`PKT_OUT_W-1:0] pkt_t;

    // operand memory address and data words
    typedef logic [`PKT_FIL_ADDR_W-1:0] fil_addr_t;
    typedef logic [`PKT_IF_ADDR_W-1:0]  if_addr_t;
    typedef logic [`PKT_FIL_DATA_W-1:0] fil_data_t;
    typedef logic [`PKT_IF_DATA_W-1:0]  if_data_t;

    // request fields
    // destination PE node
    localparam int req_node_msb = 3;
    localparam int req_node_lsb = 0;
    // 1 = filter job, 0 = ifmap job
    localparam int req_job_bit = 4;
    // filter row for filter jobs
    localparam int req_row_msb = 7;
    localparam int req_row_lsb = 5;
    // ifmap jobs: timestep, then x and y location
    localparam int req_ts_bit = 5;
    localparam int req_loc_msb = 17;
    localparam int req_loc_lsb = 6;
    // ifmap read address starts at the timestep bit
    localparam int req_if_addr_lsb = 5;

    // packet fields
    localparam int pkt_hdr_msb = 7;
    localparam int pkt_ts_bit = 8;
    localparam int pkt_fil_bit = 9;
    localparam int pkt_row_msb = 12;
    localparam int pkt_row_lsb = 10;
    localparam int pkt_fsz_msb = 14;
    localparam int pkt_fsz_lsb = 13;
    localparam int pkt_loc_msb = 26;
    localparam int pkt_loc_lsb = 15;
    localparam int pkt_fil_data_lsb = 13;
    localparam int pkt_if_data_lsb = 28;

    // routing header per PE node
    // nodes 14 and 15 fall back to the node 0 route
    localparam logic [7:0] hdr_table [16] = '{
        8'hE3, 8'hF3, 8'hFB, 8'hC3,
        8'hD3, 8'hDB, 8'hDF, 8'h83,
        8'h93, 8'h9B, 8'h9F, 8'h13,
        8'h1B, 8'h1F, 8'hE3, 8'hE3
    };

endpackage

/* verilog/pkt_defines.svh */
`ifndef PKT_DEFINES_SVH
`define PKT_DEFINES_SVH

// work request from the scheduler
`define PKT_REQ_W 18

// network packet toward the PE array
`define PKT_OUT_W 53

// operand word widths
`define PKT_FIL_DATA_W 40
`define PKT_IF_DATA_W 25

// filter memory is addressed by the 3-bit filter row
`define PKT_FIL_ADDR_W 3

// ifmap address is request bits 17:5
`define PKT_IF_ADDR_W 13

// request buffer entries
`define PKT_FIFO_DEPTH 4

`endif
